// ==== rtl/y86_fetch_pkg.sv ====
package y86_fetch_pkg;

	localparam int ADDR_W = 64; // program counter
	localparam int WORD_W = 64; // valC
	localparam logic [3:0] REG_NONE = 4'hF;

	// y86 opcodes, 0xC..0xF unused
	typedef enum logic [3:0] {
		HALT   = 4'h0,
		NOP    = 4'h1,
		RRMOVQ = 4'h2,
		IRMOVQ = 4'h3,
		RMMOVQ = 4'h4,
		MRMOVQ = 4'h5,
		OPQ    = 4'h6,
		JXX    = 4'h7,
		CALL   = 4'h8,
		RET    = 4'h9,
		PUSHQ  = 4'hA,
		POPQ   = 4'hB
	} icode_t;

	typedef enum logic [1:0] {
		AOK = 2'd0,
		HLT = 2'd1,
		ADR = 2'd2, // fetch past end of memory
		INS = 2'd3  // bad icode or ifun
	} stat_t;

	// instruction length in bytes
	function automatic logic [3:0] instr_len(input icode_t icode);
		case (icode)
			RRMOVQ, OPQ, PUSHQ, POPQ: return 4'd2;
			JXX, CALL:                return 4'd9;
			IRMOVQ, RMMOVQ, MRMOVQ:   return 4'd10;
			default:                  return 4'd1; // halt, nop, ret and junk
		endcase
	endfunction

	function automatic logic ifun_ok(input icode_t icode, input logic [3:0] ifun);
		case (icode)
			OPQ:         return ifun <= 4'd3;
			JXX, RRMOVQ: return ifun <= 4'd6; // condition codes
			HALT, NOP, IRMOVQ, RMMOVQ, MRMOVQ,
			CALL, RET, PUSHQ, POPQ: return ifun == 4'd0;
			default:     return 1'b0; // not an opcode at all
		endcase
	endfunction

endpackage

// ==== rtl/imem_if.sv ====
`timescale 1ns/1ps

interface imem_if;
	import y86_fetch_pkg::*;

	logic              req_valid;
	logic [ADDR_W-1:0] req_addr;
	logic              req_ready; // low during a load write
	logic              rsp_valid;
	logic [7:0]        rsp_byte0;
	logic [71:0]       rsp_bytes19; // byte 1 in bits 7:0
	logic              rsp_error;

	modport requester (
		output req_valid, req_addr,
		input  req_ready, rsp_valid, rsp_byte0, rsp_bytes19, rsp_error
	);

	modport responder (
		input  req_valid, req_addr,
		output req_ready, rsp_valid, rsp_byte0, rsp_bytes19, rsp_error
	);

endinterface

// ==== rtl/instr_mem.sv ====
`timescale 1ns/1ps

module instr_mem #(
	parameter int MEM_BYTES = 2048
) (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         load_valid,
	input  logic [$clog2(MEM_BYTES)-1:0] load_addr,
	input  logic [7:0]                   load_data,
	imem_if.responder                    bus
);
	import y86_fetch_pkg::*;

	localparam int AW = $clog2(MEM_BYTES);

	logic [7:0] mem [MEM_BYTES];

	logic          accept;
	logic          out_of_range;
	logic [AW-1:0] base;

	// load port has priority over fetch
	assign bus.req_ready = !load_valid;
	assign accept = bus.req_valid && bus.req_ready;

	// last byte of a ten byte window must still be inside the array
	assign out_of_range = bus.req_addr > ADDR_W'(MEM_BYTES - 10);
	assign base = bus.req_addr[AW-1:0];

	always_ff @(posedge clk) begin
		if (load_valid) begin
			mem[load_addr] <= load_data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			bus.rsp_valid <= 1'b0;
		end else begin
			bus.rsp_valid <= accept; // one cycle after the request
		end
	end

	// response bytes are zeroed on a bounds error
	always_ff @(posedge clk) begin
		if (accept) begin
			bus.rsp_error <= out_of_range;
			bus.rsp_byte0 <= out_of_range ? 8'h00 : mem[base];
			for (int k = 1; k < 10; k++) begin
				bus.rsp_bytes19[8*k-8 +: 8] <= out_of_range ? 8'h00 : mem[base + AW'(k)];
			end
		end
	end

	// only one fetch may be in flight at a time
	a_one_in_flight: assert property (
		@(posedge clk) disable iff (rst)
		(bus.req_valid && bus.req_ready) |=> !bus.req_valid
	) else $error("instr_mem: new request while a response is pending");

endmodule

// ==== rtl/instr_split.sv ====
`timescale 1ns/1ps

module instr_split (
	input  logic [7:0]                       byte0,
	input  logic [71:0]                      bytes19,
	input  logic [y86_fetch_pkg::ADDR_W-1:0] pc,
	input  logic                             mem_error,
	output y86_fetch_pkg::icode_t            icode,
	output logic [3:0]                       ifun,
	output logic [3:0]                       ra,
	output logic [3:0]                       rb,
	output logic [y86_fetch_pkg::WORD_W-1:0] valc,
	output logic [y86_fetch_pkg::ADDR_W-1:0] valp,
	output y86_fetch_pkg::stat_t             stat
);
	import y86_fetch_pkg::*;

	logic has_regs;
	logic icode_legal;

	assign icode = icode_t'(byte0[7:4]);
	assign ifun  = byte0[3:0];
	assign icode_legal = byte0[7:4] <= 4'hB; // 0xC and up are unused

	// which opcodes carry a register byte
	always_comb begin
		case (icode)
			RRMOVQ, IRMOVQ, RMMOVQ, MRMOVQ, OPQ, PUSHQ, POPQ: has_regs = 1'b1;
			default: has_regs = 1'b0;
		endcase
	end

	assign ra = has_regs ? bytes19[7:4] : REG_NONE;
	assign rb = has_regs ? bytes19[3:0] : REG_NONE;

	// constant, little endian
	always_comb begin
		case (icode)
			IRMOVQ, RMMOVQ, MRMOVQ: valc = bytes19[71:8]; // bytes 2..9
			JXX, CALL:              valc = bytes19[63:0]; // bytes 1..8, no reg byte
			default:                valc = '0;
		endcase
	end

	assign valp = pc + ADDR_W'(instr_len(icode));

	// address error wins over everything else
	always_comb begin
		if (mem_error) begin
			stat = ADR;
		end else if (icode == HALT) begin
			stat = HLT;
		end else if (!icode_legal || !ifun_ok(icode, ifun)) begin
			stat = INS;
		end else begin
			stat = AOK;
		end
	end

endmodule

// ==== rtl/fetch_ctrl.sv ====
`timescale 1ns/1ps

module fetch_ctrl (
	input  logic                             clk,
	input  logic                             rst,
	input  logic                             start,
	input  logic [y86_fetch_pkg::ADDR_W-1:0] start_pc,
	imem_if.requester                        bus,
	output logic [y86_fetch_pkg::ADDR_W-1:0] pc,
	input  y86_fetch_pkg::icode_t            sp_icode,
	input  logic [3:0]                       sp_ifun,
	input  logic [3:0]                       sp_ra,
	input  logic [3:0]                       sp_rb,
	input  logic [y86_fetch_pkg::WORD_W-1:0] sp_valc,
	input  logic [y86_fetch_pkg::ADDR_W-1:0] sp_valp,
	input  y86_fetch_pkg::stat_t             sp_stat,
	output logic                             out_valid,
	input  logic                             out_ready,
	output logic [y86_fetch_pkg::ADDR_W-1:0] out_pc,
	output y86_fetch_pkg::icode_t            out_icode,
	output logic [3:0]                       out_ifun,
	output logic [3:0]                       out_ra,
	output logic [3:0]                       out_rb,
	output logic [y86_fetch_pkg::WORD_W-1:0] out_valc,
	output logic [y86_fetch_pkg::ADDR_W-1:0] out_valp,
	output y86_fetch_pkg::stat_t             out_stat,
	input  logic                             redirect_valid,
	input  logic [y86_fetch_pkg::ADDR_W-1:0] redirect_pc
);
	import y86_fetch_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		REQ,
		WAIT,
		HOLD
	} state_t;

	state_t state;

	assign bus.req_valid = state == REQ;
	assign bus.req_addr  = pc;
	assign out_valid     = state == HOLD;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: if (start) state <= REQ; // start ignored elsewhere
				REQ:  if (bus.req_ready) state <= WAIT;
				WAIT: if (bus.rsp_valid) state <= HOLD;
				HOLD: if (out_ready) state <= (out_stat == AOK) ? REQ : IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	// pc and output payload
	always_ff @(posedge clk) begin
		if (state == IDLE && start) begin
			pc <= start_pc;
		end else if (state == HOLD && out_ready) begin
			pc <= redirect_valid ? redirect_pc : out_valp;
		end
		if (state == WAIT && bus.rsp_valid) begin
			out_pc    <= pc;
			out_icode <= sp_icode;
			out_ifun  <= sp_ifun;
			out_ra    <= sp_ra;
			out_rb    <= sp_rb;
			out_valc  <= sp_valc;
			out_valp  <= sp_valp;
			out_stat  <= sp_stat;
		end
	end

	// memory must answer exactly one cycle after accepting
	a_rsp_next_cycle: assert property (
		@(posedge clk) disable iff (rst)
		(bus.req_valid && bus.req_ready) |=> bus.rsp_valid
	) else $error("fetch_ctrl: memory response missing");

	a_payload_hold: assert property (
		@(posedge clk) disable iff (rst)
		(out_valid && !out_ready) |=> (out_valid && $stable({out_pc, out_icode, out_ifun,
			out_ra, out_rb, out_valc, out_valp, out_stat}))
	) else $error("fetch_ctrl: payload changed under back-pressure");

endmodule

// ==== rtl/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top #(
	parameter int MEM_BYTES = 2048
) (
	input  logic                             clk,
	input  logic                             rst,
	input  logic                             load_valid,
	input  logic [$clog2(MEM_BYTES)-1:0]     load_addr,
	input  logic [7:0]                       load_data,
	input  logic                             start,
	input  logic [y86_fetch_pkg::ADDR_W-1:0] start_pc,
	output logic                             out_valid,
	input  logic                             out_ready,
	output logic [y86_fetch_pkg::ADDR_W-1:0] out_pc,
	output y86_fetch_pkg::icode_t            out_icode,
	output logic [3:0]                       out_ifun,
	output logic [3:0]                       out_ra,
	output logic [3:0]                       out_rb,
	output logic [y86_fetch_pkg::WORD_W-1:0] out_valc,
	output logic [y86_fetch_pkg::ADDR_W-1:0] out_valp,
	output y86_fetch_pkg::stat_t             out_stat,
	input  logic                             redirect_valid,
	input  logic [y86_fetch_pkg::ADDR_W-1:0] redirect_pc
);
	import y86_fetch_pkg::*;

	logic [ADDR_W-1:0] pc;
	icode_t            sp_icode;
	logic [3:0]        sp_ifun;
	logic [3:0]        sp_ra;
	logic [3:0]        sp_rb;
	logic [WORD_W-1:0] sp_valc;
	logic [ADDR_W-1:0] sp_valp;
	stat_t             sp_stat;

	imem_if fetch_bus ();

	instr_mem #(
		.MEM_BYTES(MEM_BYTES)
	) u_mem (
		.clk(clk), .rst(rst),
		.load_valid(load_valid), .load_addr(load_addr), .load_data(load_data),
		.bus(fetch_bus.responder)
	);

	// decodes whatever the memory is currently presenting
	instr_split u_split (
		.byte0(fetch_bus.rsp_byte0), .bytes19(fetch_bus.rsp_bytes19),
		.pc(pc), .mem_error(fetch_bus.rsp_error),
		.icode(sp_icode), .ifun(sp_ifun), .ra(sp_ra), .rb(sp_rb),
		.valc(sp_valc), .valp(sp_valp), .stat(sp_stat)
	);

	fetch_ctrl u_ctrl (
		.clk(clk), .rst(rst), .start(start), .start_pc(start_pc),
		.bus(fetch_bus.requester), .pc(pc),
		.sp_icode(sp_icode), .sp_ifun(sp_ifun), .sp_ra(sp_ra), .sp_rb(sp_rb),
		.sp_valc(sp_valc), .sp_valp(sp_valp), .sp_stat(sp_stat),
		.out_valid(out_valid), .out_ready(out_ready),
		.out_pc(out_pc), .out_icode(out_icode), .out_ifun(out_ifun),
		.out_ra(out_ra), .out_rb(out_rb), .out_valc(out_valc),
		.out_valp(out_valp), .out_stat(out_stat),
		.redirect_valid(redirect_valid), .redirect_pc(redirect_pc)
	);

endmodule

// ==== verif/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
	parameter int PERIOD     = 10,
	parameter int RST_CYCLES = 3
) (
	output logic clk,
	output logic rst
);
	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	initial begin
		rst = 1'b1;
		repeat (RST_CYCLES) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

// ==== verif/fetch_tb.sv ====
`timescale 1ns/1ps

module fetch_tb;
	import y86_fetch_pkg::*;

	localparam int MEM_BYTES = 2048;
	localparam int AW        = 11;
	localparam int NPROG     = 8;

	logic              clk;
	logic              rst;
	logic              load_valid;
	logic [AW-1:0]     load_addr;
	logic [7:0]        load_data;
	logic              start;
	logic [ADDR_W-1:0] start_pc;
	logic              out_valid;
	logic              out_ready;
	logic [ADDR_W-1:0] out_pc;
	icode_t            out_icode;
	logic [3:0]        out_ifun;
	logic [3:0]        out_ra;
	logic [3:0]        out_rb;
	logic [WORD_W-1:0] out_valc;
	logic [ADDR_W-1:0] out_valp;
	stat_t             out_stat;
	logic              redirect_valid;
	logic [ADDR_W-1:0] redirect_pc;

	logic [7:0] model [MEM_BYTES]; // byte image of the instruction store
	integer     seed = 32'h2cb5;
	int         cycles = 0;
	int         limit = 1000000;
	int         n_body [NPROG];
	int         bounds [$]; // instruction start addresses of the current program

	tb_clk_gen #(.PERIOD(10), .RST_CYCLES(3)) u_clk (.clk(clk), .rst(rst));

	fetch_top #(.MEM_BYTES(MEM_BYTES)) dut (
		.clk(clk), .rst(rst),
		.load_valid(load_valid), .load_addr(load_addr), .load_data(load_data),
		.start(start), .start_pc(start_pc),
		.out_valid(out_valid), .out_ready(out_ready),
		.out_pc(out_pc), .out_icode(out_icode), .out_ifun(out_ifun),
		.out_ra(out_ra), .out_rb(out_rb), .out_valc(out_valc),
		.out_valp(out_valp), .out_stat(out_stat),
		.redirect_valid(redirect_valid), .redirect_pc(redirect_pc)
	);

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > limit) begin
			$display("timeout: fetch stage stalled, run exceeded %0d cycles", limit);
			$display("Verification failed");
			$fatal(1, "timeout");
		end
	end

	function automatic int rnd(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	task automatic report_mismatch(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		$display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
		$display("Verification failed");
		$fatal(1, "mismatch on %s", name);
	endtask

	task automatic check_instr(input logic [ADDR_W-1:0] pc, input icode_t icode,
			input logic [3:0] ifun, input logic [3:0] ra, input logic [3:0] rb,
			input logic [WORD_W-1:0] valc, input logic [ADDR_W-1:0] valp);
		if (out_pc !== pc) report_mismatch("out_pc", out_pc, pc);
		if (out_icode !== icode) report_mismatch("out_icode", 64'(out_icode), 64'(icode));
		if (out_ifun !== ifun) report_mismatch("out_ifun", 64'(out_ifun), 64'(ifun));
		if (out_ra !== ra) report_mismatch("out_ra", 64'(out_ra), 64'(ra));
		if (out_rb !== rb) report_mismatch("out_rb", 64'(out_rb), 64'(rb));
		if (out_valc !== valc) report_mismatch("out_valc", out_valc, valc);
		if (out_valp !== valp) report_mismatch("out_valp", out_valp, valp);
	endtask

	task automatic check_stat(input stat_t stat);
		if (out_stat !== stat) report_mismatch("out_stat", 64'(out_stat), 64'(stat));
	endtask

	task automatic write_byte(input int addr, input logic [7:0] data);
		@(negedge clk);
		load_valid = 1'b1;
		load_addr = AW'(addr);
		load_data = data;
		model[addr] = data;
	endtask

	// opcode byte plus random register and constant bytes
	task automatic put_instr(input int addr, input logic [3:0] ic, input logic [3:0] fn,
			output int len);
		len = int'(instr_len(icode_t'(ic)));
		write_byte(addr, {ic, fn});
		for (int k = 1; k < len; k++) begin
			write_byte(addr + k, 8'(rnd(256)));
		end
	endtask

	task automatic gen_program(input int base, input int n);
		int a;
		int len;
		logic [3:0] ic;
		logic [3:0] fn;
		a = base;
		bounds.delete();
		for (int i = 0; i <= n; i++) begin
			bounds.push_back(a);
			fn = 4'h0;
			if (i == n) begin
				ic = (rnd(4) == 0) ? 4'(12 + rnd(4)) : 4'h0; // halt, or a bad opcode
			end else if (rnd(14) == 0) begin
				ic = 4'h6;
				fn = 4'(7 + rnd(9)); // illegal alu function
			end else begin
				ic = 4'(1 + rnd(11));
				if (ic == 4'h6) fn = 4'(rnd(4));
				else if (ic == 4'h2 || ic == 4'h7) fn = 4'(rnd(7));
			end
			put_instr(a, ic, fn, len);
			a += len;
		end
		@(negedge clk);
		load_valid = 1'b0;
	endtask

	task automatic run_program(input logic [ADDR_W-1:0] pc0);
		logic [ADDR_W-1:0] pc;
		logic [7:0]        b [10];
		icode_t            ic;
		logic [3:0]        fn;
		logic [WORD_W-1:0] valc;
		stat_t             st;
		logic              adr;
		logic              regs;
		int                idx;
		int                j;
		bit                done;
		@(negedge clk);
		start = 1'b1;
		start_pc = pc0;
		@(negedge clk);
		start = 1'b0;
		pc = pc0;
		idx = 0;
		done = 0;
		while (!done) begin
			adr = pc + ADDR_W'(9) >= ADDR_W'(MEM_BYTES); // tenth byte lies past the end
			for (int k = 0; k < 10; k++) b[k] = adr ? 8'h00 : model[int'(pc) + k];
			ic = icode_t'(b[0][7:4]);
			fn = b[0][3:0];
			regs = b[0][7:4] inside {4'h2, 4'h3, 4'h4, 4'h5, 4'h6, 4'hA, 4'hB};
			valc = '0;
			if (b[0][7:4] inside {4'h3, 4'h4, 4'h5})
				valc = {b[9], b[8], b[7], b[6], b[5], b[4], b[3], b[2]};
			if (b[0][7:4] inside {4'h7, 4'h8})
				valc = {b[8], b[7], b[6], b[5], b[4], b[3], b[2], b[1]};
			if (adr) st = ADR;
			else if (b[0][7:4] == 4'h0) st = HLT;
			else if (b[0][7:4] > 4'hB || !ifun_ok(ic, fn)) st = INS;
			else st = AOK;
			out_ready = rnd(4) != 0;
			redirect_valid = 1'b0;
			if (out_valid) begin
				// checked every cycle, so a held payload is checked too
				check_instr(pc, ic, fn, regs ? b[1][7:4] : REG_NONE,
					regs ? b[1][3:0] : REG_NONE, valc, pc + ADDR_W'(instr_len(ic)));
				check_stat(st);
				if (out_ready) begin
					if (st != AOK) begin
						done = 1;
					end else if (rnd(5) == 0 && idx + 1 < bounds.size()) begin
						j = idx + 1 + rnd(bounds.size() - idx - 1); // forward only
						redirect_valid = 1'b1;
						redirect_pc = ADDR_W'(bounds[j]);
						pc = redirect_pc;
						idx = j;
					end else begin
						pc = pc + ADDR_W'(instr_len(ic));
						idx++;
					end
				end
			end
			@(negedge clk);
		end
		out_ready = 1'b1;
		redirect_valid = 1'b0;
		repeat (10) begin
			@(negedge clk);
			if (out_valid) begin
				$display("out_valid rose after the final record without a new start");
				$display("Verification failed");
				$fatal(1, "output after final record");
			end
		end
	endtask

	initial begin
		int total;
		load_valid = 1'b0;
		load_addr = '0;
		load_data = '0;
		start = 1'b0;
		start_pc = '0;
		out_ready = 1'b0;
		redirect_valid = 1'b0;
		redirect_pc = '0;
		total = 1; // the end of memory run
		for (int p = 0; p < NPROG; p++) begin
			n_body[p] = 3 + rnd(6);
			total += n_body[p] + 1;
		end
		limit = 60 * total;
		@(negedge clk);
		while (rst) @(negedge clk);
		for (int p = 0; p < NPROG; p++) begin
			gen_program(16 + 200 * p, n_body[p]);
			run_program(ADDR_W'(bounds[0]));
		end
		bounds.delete();
		run_program(ADDR_W'(MEM_BYTES - 1 - rnd(9)));
		$display("Verification passed");
		$finish;
	end

endmodule

// ==== flist.f ====
rtl/y86_fetch_pkg.sv
rtl/imem_if.sv
rtl/instr_mem.sv
rtl/instr_split.sv
rtl/fetch_ctrl.sv
rtl/fetch_top.sv
verif/tb_clk_gen.sv
verif/fetch_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= fetch_tb
FLIST     ?= flist.f
BUILD     ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf $(BUILD)
